// ==== source/md_types_pkg.sv ====
/*
 * Positions are fixed-point words of three 16-bit coordinates, z in the top bits.
 * Bank size is a power of two so the address width follows from the capacity.
 */
package md_types_pkg;

	////////////////////////////////////////////////////////////
	// Position word layout
	////////////////////////////////////////////////////////////

	// One coordinate axis
	localparam int COORD_WIDTH = 16;

	// Stored as {z, y, x}
	localparam int POS_WIDTH = 3 * COORD_WIDTH;

	// Address 0 of a bank reuses this word for the particle count
	typedef logic [POS_WIDTH-1:0] pos_t;

	////////////////////////////////////////////////////////////
	// Bank sizing
	////////////////////////////////////////////////////////////

	// Address 0 counts toward the capacity
	localparam int CELL_CAPACITY = 16;

	localparam int BANK_ADDR_WIDTH = $clog2(CELL_CAPACITY);

	typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;

endpackage

// ==== source/cell_pkg.sv ====
/*
 * Each axis of a cell coordinate is 4 bits wide, so a cell coordinate is 12 bits.
 * Only two cells are defined here. A larger grid needs more constants.
 */
package cell_pkg;

	// Width of one axis
	localparam int CELL_ID_WIDTH = 4;

	// Packed as {cell_x, cell_y, cell_z} from the MSB down
	typedef struct packed
	{
		logic [CELL_ID_WIDTH-1:0] cell_x;
		logic [CELL_ID_WIDTH-1:0] cell_y;
		logic [CELL_ID_WIDTH-1:0] cell_z;
	} cell_id_t;

	// The two cells of this subsystem
	localparam cell_id_t CELL_A = '{cell_x: 4'd2, cell_y: 4'd2, cell_z: 4'd3};

	// Neighbour of CELL_A along z
	localparam cell_id_t CELL_B = '{cell_x: 4'd2, cell_y: 4'd2, cell_z: 4'd4};

endpackage

// ==== source/bank_if.sv ====
/*
 * One single-port position bank. The controller owns every request signal.
 * Read data lags a read request by one clock.
 */
`timescale 1ns/1ps

interface bank_if;
	import md_types_pkg::*;

	// Shared read and write address
	bank_addr_t addr;
	pos_t wdata;
	logic wren;
	logic rden;
	// Registered read data
	pos_t q;

	// Controller side
	modport ctrl
	(
		output addr,
		output wdata,
		output wren,
		output rden,
		input q
	);

	// Memory side
	modport mem
	(
		input addr,
		input wdata,
		input wren,
		input rden,
		output q
	);

endinterface

// ==== source/cell_bank.sv ====
/*
 * Single-port bank that is cleared by rst. A read and a write must not share a cycle.
 * q is updated one edge after rden and keeps its value while rden is low.
 */
`timescale 1ns/1ps

module cell_bank
(
	input logic clk,
	input logic rst,
	bank_if.mem mem
);
	import md_types_pkg::*;

	// Storage where address 0 holds the particle count
	pos_t words [CELL_CAPACITY];

	////////////////////////////////////////////////////////////
	// Write port and registered read
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			// Both banks start out empty
			for (int i = 0; i < CELL_CAPACITY; i++)
			begin
				words[i] <= '0;
			end
			mem.q <= '0;
		end
		else
		begin
			if (mem.wren)
			begin
				words[mem.addr] <= mem.wdata;
			end
			// Hold last word when idle
			if (mem.rden)
			begin
				mem.q <= words[mem.addr];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// The controller steers reads and writes to opposite banks,
	// so a bank never sees both in one cycle
	a_no_rd_wr_collision: assert property (
		@(posedge clk) disable iff (rst)
		!(mem.rden && mem.wren)
	)
	else
		$error("cell_bank: read and write in the same cycle");

endmodule

// ==== source/pos_cache.sv ====
/*
 * Double-buffered cache for one cell. motion_update_enable is a level held for the update.
 * There is no overflow handling. The caller keeps each update within CELL_CAPACITY - 1 beats.
 */
`timescale 1ns/1ps

module pos_cache
#(
	parameter cell_pkg::cell_id_t MY_CELL = cell_pkg::CELL_A
)
(
	input logic clk,
	input logic rst,
	input logic motion_update_enable,
	input md_types_pkg::pos_t bcast_pos,
	input cell_pkg::cell_id_t bcast_dst_cell,
	input logic bcast_valid,
	input logic rd_en,
	input md_types_pkg::bank_addr_t rd_addr,
	output md_types_pkg::pos_t particle_info
);
	import md_types_pkg::*;

	typedef enum logic [1:0]
	{
		ST_WAIT,
		ST_CAPTURE,
		ST_WRITE_COUNT,
		ST_SWAP
	} state_t;

	state_t state;

	// 0 means bank 0 serves reads and bank 1 collects
	logic active_bank;
	// Bank that served the read now in q
	logic out_sel;

	// Next write address. One wider than an address so a full bank fits
	logic [BANK_ADDR_WIDTH:0] wr_count;
	logic [BANK_ADDR_WIDTH:0] particle_count;

	// Registered write toward the collecting bank
	logic wr_en;
	bank_addr_t wr_addr;
	pos_t wr_data;

	logic hit;
	logic do_capture;
	logic do_count;

	bank_if bank_0 ();
	bank_if bank_1 ();

	////////////////////////////////////////////////////////////
	// Beat decode
	////////////////////////////////////////////////////////////

	// Accept only beats addressed to this cell while the update runs
	assign hit = motion_update_enable && bcast_valid && (bcast_dst_cell == MY_CELL);

	// A beat in the first enabled cycle is taken straight from ST_WAIT
	assign do_capture = hit && ((state == ST_WAIT) || (state == ST_CAPTURE));
	assign do_count = (state == ST_WRITE_COUNT);

	// Counter runs one ahead of the number of particles
	assign particle_count = wr_count - 1'b1;

	////////////////////////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_WAIT;
			active_bank <= 1'b0;
			wr_count <= 1;
			wr_en <= 1'b0;
		end
		else
		begin
			wr_en <= do_capture || do_count;

			// Address 0 is kept for the count
			if (do_capture)
			begin
				wr_count <= wr_count + 1'b1;
			end

			case (state)
				ST_WAIT:
				begin
					if (motion_update_enable)
					begin
						state <= ST_CAPTURE;
					end
				end
				// Enable low closes the update
				ST_CAPTURE:
				begin
					if (!motion_update_enable)
					begin
						state <= ST_WRITE_COUNT;
					end
				end
				// Count write is queued by the wr_en update above
				ST_WRITE_COUNT:
				begin
					state <= ST_SWAP;
				end
				// First cycle lets the count land in address 0
				// and the second cycle flips the banks
				ST_SWAP:
				begin
					if (!wr_en)
					begin
						active_bank <= ~active_bank;
						wr_count <= 1;
						state <= ST_WAIT;
					end
				end
				default:
				begin
					state <= ST_WAIT;
				end
			endcase
		end
	end

	// Write payload that wr_en qualifies
	always_ff @(posedge clk)
	begin
		if (do_capture)
		begin
			wr_addr <= wr_count[BANK_ADDR_WIDTH-1:0];
			wr_data <= bcast_pos;
		end
		else if (do_count)
		begin
			wr_addr <= '0;
			// Zero-extended into the position word
			wr_data <= pos_t'(particle_count);
		end
	end

	// Follows active_bank by one edge to match the bank read latency
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out_sel <= 1'b0;
		end
		else
		begin
			out_sel <= active_bank;
		end
	end

	////////////////////////////////////////////////////////////
	// Bank steering
	////////////////////////////////////////////////////////////
	always_comb
	begin
		// Reads go to the active bank and writes to the other one
		bank_0.addr = active_bank ? wr_addr : rd_addr;
		bank_0.wdata = wr_data;
		bank_0.wren = wr_en && active_bank;
		bank_0.rden = rd_en && !active_bank;

		bank_1.addr = active_bank ? rd_addr : wr_addr;
		bank_1.wdata = wr_data;
		bank_1.wren = wr_en && !active_bank;
		bank_1.rden = rd_en && active_bank;
	end

	// A read issued just before a flip still returns from the old bank
	assign particle_info = out_sel ? bank_1.q : bank_0.q;

	cell_bank mem_0
	(
		.clk(clk),
		.rst(rst),
		.mem(bank_0.mem)
	);

	cell_bank mem_1
	(
		.clk(clk),
		.rst(rst),
		.mem(bank_1.mem)
	);

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// A full bank puts the counter at CELL_CAPACITY. One beat more would wrap address 0
	a_count_in_range: assert property (
		@(posedge clk) disable iff (rst)
		wr_count <= CELL_CAPACITY
	)
	else
		$error("pos_cache: bank overflow, write counter %0d", wr_count);

	// No write may still be pending once a bank has become the read bank
	a_no_write_to_active: assert property (
		@(posedge clk) disable iff (rst)
		$changed(active_bank) |-> !wr_en && !bank_0.wren && !bank_1.wren
	)
	else
		$error("pos_cache: write reaching the newly active bank");

endmodule

// ==== source/pos_cache_array.sv ====
/*
 * Two cell caches that share one broadcast bus and one read port.
 * A read has a fixed latency of 2 cycles. rd_cell_sel set to 0 selects CELL_A.
 */
`timescale 1ns/1ps

module pos_cache_array
(
	input logic clk,
	input logic rst,
	input logic motion_update_enable,
	input md_types_pkg::pos_t bcast_pos,
	input cell_pkg::cell_id_t bcast_dst_cell,
	input logic bcast_valid,
	input logic rd_cell_sel,
	input md_types_pkg::bank_addr_t rd_addr,
	input logic rd_en,
	output md_types_pkg::pos_t particle_info
);
	import md_types_pkg::*;
	import cell_pkg::*;

	// Per-cell read strobes
	logic rd_en_a;
	logic rd_en_b;

	// Select lined up with bank read data
	logic rd_sel_q;

	pos_t info_a;
	pos_t info_b;

	////////////////////////////////////////////////////////////
	// Read port fan-out
	////////////////////////////////////////////////////////////

	// Only the selected cell sees the strobe
	assign rd_en_a = rd_en && !rd_cell_sel;
	assign rd_en_b = rd_en && rd_cell_sel;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_sel_q <= 1'b0;
		end
		else
		begin
			rd_sel_q <= rd_cell_sel;
		end
	end

	// Second latency stage
	always_ff @(posedge clk)
	begin
		particle_info <= rd_sel_q ? info_b : info_a;
	end

	////////////////////////////////////////////////////////////
	// Cell caches
	////////////////////////////////////////////////////////////

	// Each cell compares every beat against its own coordinate
	pos_cache
	#(
		.MY_CELL(CELL_A)
	)
	cache_a
	(
		.clk(clk),
		.rst(rst),
		.motion_update_enable(motion_update_enable),
		.bcast_pos(bcast_pos),
		.bcast_dst_cell(bcast_dst_cell),
		.bcast_valid(bcast_valid),
		.rd_en(rd_en_a),
		.rd_addr(rd_addr),
		.particle_info(info_a)
	);

	pos_cache
	#(
		.MY_CELL(CELL_B)
	)
	cache_b
	(
		.clk(clk),
		.rst(rst),
		.motion_update_enable(motion_update_enable),
		.bcast_pos(bcast_pos),
		.bcast_dst_cell(bcast_dst_cell),
		.bcast_valid(bcast_valid),
		.rd_en(rd_en_b),
		.rd_addr(rd_addr),
		.particle_info(info_b)
	);

endmodule

// ==== dv/tb_pos_cache_array.sv ====
/*
 * Testbench for the two-cell position cache. Every read is checked by an assertion two cycles
 * after issue. Updates hold 9 beats, so no bank can overflow.
 */
`timescale 1ns/1ps

module tb_pos_cache_array;
	import md_types_pkg::*;
	import cell_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 3;
	localparam int UPDATE_BEATS = 9;
	// Tests need about 200 cycles
	localparam int TIMEOUT_CYCLES = 2000;
	// Cell that neither cache owns
	localparam cell_id_t CELL_FOREIGN = '{cell_x: 4'd7, cell_y: 4'd1, cell_z: 4'd0};

	logic clk;
	logic rst;
	logic motion_update_enable;
	pos_t bcast_pos;
	cell_id_t bcast_dst_cell;
	logic bcast_valid;
	logic rd_cell_sel;
	bank_addr_t rd_addr;
	logic rd_en;
	pos_t particle_info;

	// Reference banks indexed by cell, bank and address
	pos_t model_mem [2][2][CELL_CAPACITY];
	// Bank that serves reads in the model
	logic model_active;
	// Particles captured per cell during the running update
	pos_t captured [2][$];

	// Expected word of the read being issued
	pos_t rd_exp;
	// Two-stage read tracker that matches the read latency
	logic trk_valid_1;
	logic trk_valid_2;
	pos_t trk_exp_1;
	pos_t trk_exp_2;

	string test_name;
	int reads_issued = 0;
	int checks_done = 0;
	int cycle_count = 0;
	logic [31:0] lcg_state;

	pos_cache_array DUT
	(
		.clk(clk),
		.rst(rst),
		.motion_update_enable(motion_update_enable),
		.bcast_pos(bcast_pos),
		.bcast_dst_cell(bcast_dst_cell),
		.bcast_valid(bcast_valid),
		.rd_cell_sel(rd_cell_sel),
		.rd_addr(rd_addr),
		.rd_en(rd_en),
		.particle_info(particle_info)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Read tracking and checks
	////////////////////////////////////////////////////////////
	always @(posedge clk)
	begin
		if (rst)
		begin
			trk_valid_1 <= 1'b0;
			trk_valid_2 <= 1'b0;
		end
		else
		begin
			trk_valid_1 <= rd_en;
			trk_exp_1 <= rd_exp;
			trk_valid_2 <= trk_valid_1;
			trk_exp_2 <= trk_exp_1;
			// Same edge as the assertion below
			if (trk_valid_2)
			begin
				checks_done <= checks_done + 1;
			end
		end
	end

	// Read data lands two edges after the strobe is sampled
	a_read_data: assert property (
		@(posedge clk) disable iff (rst)
		trk_valid_2 |-> (particle_info == trk_exp_2)
	)
	else
	begin
		$display("ERR %s: expected %h actual %h", test_name,
			$sampled(trk_exp_2), $sampled(particle_info));
		$display("CHECKS FAILED");
		$fatal(1, "read data mismatch");
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$fatal(1, "timeout");
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	// Multiplier and increment of the classic C library rand
	function automatic logic [31:0] lcg_next(input logic [31:0] cur);
		return cur * 32'd1103515245 + 32'd12345;
	endfunction

	// Back-to-back reads over the whole bank of one cell
	task automatic read_cell(input logic sel);
		for (int a = 0; a < CELL_CAPACITY; a++)
		begin
			@(posedge clk);
			rd_en <= 1'b1;
			rd_cell_sel <= sel;
			rd_addr <= bank_addr_t'(a);
			rd_exp <= model_mem[sel][model_active][a];
			reads_issued++;
		end
		@(posedge clk);
		rd_en <= 1'b0;
		// Let the last checks retire under this test name
		repeat (3) @(posedge clk);
	endtask

	// Count word into address 0, then the banks trade roles
	task automatic commit_model();
		logic coll;
		coll = !model_active;
		for (int c = 0; c < 2; c++)
		begin
			for (int k = 0; k < captured[c].size(); k++)
			begin
				model_mem[c][coll][k + 1] = captured[c][k];
			end
			model_mem[c][coll][0] = pos_t'(captured[c].size());
			captured[c].delete();
		end
		model_active = coll;
	endtask

	// One update with a read of the old bank in every beat cycle
	task automatic run_update();
		logic valid;
		cell_id_t dst;
		pos_t pos;
		int pick;
		for (int i = 0; i < UPDATE_BEATS; i++)
		begin
			lcg_state = lcg_next(lcg_state);
			pos[47:32] = lcg_state[31:16];
			lcg_state = lcg_next(lcg_state);
			pos[31:0] = lcg_state;
			lcg_state = lcg_next(lcg_state);
			valid = (lcg_state[31:30] != 2'b00);
			pick = lcg_state[29:24] % 3;
			dst = (pick == 0) ? CELL_A : ((pick == 1) ? CELL_B : CELL_FOREIGN);
			// Fixed beats for the first enabled cycle, an invalid beat,
			// a foreign beat and one beat that CELL_B always receives
			if (i == 0)
			begin
				valid = 1'b1;
				dst = CELL_A;
			end
			else if (i == 1)
			begin
				valid = 1'b0;
				dst = CELL_B;
			end
			else if (i == 2)
			begin
				valid = 1'b1;
				dst = CELL_FOREIGN;
			end
			else if (i == 3)
			begin
				valid = 1'b1;
				dst = CELL_B;
			end
			if (valid && dst == CELL_A)
			begin
				captured[0].push_back(pos);
			end
			if (valid && dst == CELL_B)
			begin
				captured[1].push_back(pos);
			end

			@(posedge clk);
			motion_update_enable <= 1'b1;
			bcast_valid <= valid;
			bcast_dst_cell <= dst;
			bcast_pos <= pos;
			rd_en <= 1'b1;
			rd_cell_sel <= i[0];
			rd_addr <= bank_addr_t'(i);
			rd_exp <= model_mem[i % 2][model_active][i];
			reads_issued++;
		end
		@(posedge clk);
		motion_update_enable <= 1'b0;
		bcast_valid <= 1'b0;
		rd_en <= 1'b0;
		commit_model();
		// Count write and swap finish well inside this gap
		repeat (8) @(posedge clk);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		lcg_state = 32'd6;
		rst = 1'b1;
		motion_update_enable = 1'b0;
		bcast_pos = '0;
		bcast_dst_cell = '0;
		bcast_valid = 1'b0;
		rd_cell_sel = 1'b0;
		rd_addr = '0;
		rd_en = 1'b0;
		rd_exp = '0;
		model_active = 1'b0;
		for (int c = 0; c < 2; c++)
		begin
			for (int a = 0; a < CELL_CAPACITY; a++)
			begin
				model_mem[c][0][a] = '0;
				model_mem[c][1][a] = '0;
			end
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;

		test_name = "reset_zero";
		read_cell(1'b0);
		read_cell(1'b1);

		test_name = "first_update";
		run_update();
		read_cell(1'b0);
		read_cell(1'b1);

		// Reads during this update still see the first update
		test_name = "second_update";
		run_update();
		read_cell(1'b0);
		read_cell(1'b1);

		if (reads_issued > 0 && checks_done == reads_issued)
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
		else
		begin
			$display("Only %0d of %0d reads reached a check", checks_done, reads_issued);
			$display("CHECKS FAILED");
			$fatal(1, "missing checks");
		end
	end

endmodule

// ==== compile.f ====
source/md_types_pkg.sv
source/cell_pkg.sv
source/bank_if.sv
source/cell_bank.sv
source/pos_cache.sv
source/pos_cache_array.sv
dv/tb_pos_cache_array.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the position cache testbench with Verilator.
# The exit status is that of the simulation.

cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal \
		-f compile.f --top-module tb_pos_cache_array -o sim_tb \
	&& ./obj_dir/sim_tb \
	|| { echo "Simulation failed"; exit 1; }

echo "Simulation finished"
